// File: Bender.yml
package:
  name: zest_dac

sources:
  - src/zest_dac_pkg.sv
  - src/zest_reg_pkg.sv
  - src/dac_ctrl_regs.sv
  - src/dac_interp.sv
  - src/awg_player.sv
  - src/dac_output_stage.sv
  - src/zest_dac_top.sv
  - target: test
    files:
      - test/zest_dac_checker.sv
      - test/zest_dac_tb.sv

// File: src/awg_player.sv
`default_nettype none

module awg_player
    import zest_dac_pkg::*;
    import zest_reg_pkg::*;
(
    input  wire logic      dac_clk_out,
    input  wire logic      rst_n_i,
    // Playback control
    input  wire logic      run_i,
    input  wire awg_addr_t last_idx_i,
    // Table load from the register block
    input  wire logic      wr_en_i,
    input  wire awg_addr_t wr_addr_i,
    input  wire dac_word_t wr_data_i,
    // Registered waveform sample
    output dac_word_t      awg_o
);

    // ----------------------------------------------------------
    // Waveform table
    // ----------------------------------------------------------
    // Contents undefined until loaded
    dac_word_t table_q [AWG_DEPTH];
    awg_addr_t idx_q;

    always_ff @(posedge dac_clk_out) begin
        if (wr_en_i) begin
            table_q[wr_addr_i] <= wr_data_i;
        end
    end

    // ----------------------------------------------------------
    // Playback
    // ----------------------------------------------------------
    // Index walks 0 up to last_idx_i and wraps
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (!run_i) begin
            // Restart from entry 0 on the next run
            idx_q <= '0;
        end else if (idx_q >= last_idx_i) begin
            // Also catches a length shortened mid-play
            idx_q <= '0;
        end else begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Entry 0 shows one cycle after run is seen
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            awg_o <= '0;
        end else if (run_i) begin
            awg_o <= table_q[idx_q];
        end else begin
            // Quiet while stopped
            awg_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/dac_ctrl_regs.sv
`default_nettype none

module dac_ctrl_regs
    import zest_dac_pkg::*;
    import zest_reg_pkg::*;
(
    input  wire logic      dac_clk_out,
    input  wire logic      rst_n_i,
    // Register write bus
    input  wire reg_wr_t   reg_wr_i,
    // Control state to the datapath
    output dac_ctrl_t      ctrl_o,
    // AWG table write port
    output logic           awg_wr_en_o,
    output awg_addr_t      awg_wr_addr_o,
    output dac_word_t      awg_wr_data_o
);

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------
    logic in_awg_window;

    // Table window is the second quarter of the address space
    assign in_awg_window = (reg_wr_i.addr >= REG_AWG_BASE) &&
                           (reg_wr_i.addr <= REG_AWG_LAST);

    // Table write goes out in the same cycle as the bus write
    assign awg_wr_en_o   = reg_wr_i.valid && in_awg_window;
    assign awg_wr_addr_o = reg_wr_i.addr[$bits(awg_addr_t)-1:0];
    assign awg_wr_data_o = reg_wr_i.data[DAC_WIDTH-1:0];

    // ----------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            // All outputs off, unity gain
            ctrl_o.awg_run     <= 1'b0;
            ctrl_o.dac1_enable <= 1'b0;
            ctrl_o.dac1_srcsel <= 1'b0;
            ctrl_o.dac0_enable <= 1'b0;
            ctrl_o.dac0_srcsel <= 1'b0;
            ctrl_o.coeff       <= COEFF_UNITY;
            // Full table by default
            ctrl_o.awg_len     <= awg_addr_t'(AWG_DEPTH - 1);
        end else if (reg_wr_i.valid) begin
            case (reg_wr_i.addr)
                REG_DAC_CTRL: begin
                    ctrl_o.dac0_srcsel <= reg_wr_i.data[BIT_DAC0_SRCSEL];
                    ctrl_o.dac0_enable <= reg_wr_i.data[BIT_DAC0_ENABLE];
                    ctrl_o.dac1_srcsel <= reg_wr_i.data[BIT_DAC1_SRCSEL];
                    ctrl_o.dac1_enable <= reg_wr_i.data[BIT_DAC1_ENABLE];
                    ctrl_o.awg_run     <= reg_wr_i.data[BIT_AWG_RUN];
                end
                REG_INTERP_COEFF: begin
                    ctrl_o.coeff <= reg_wr_i.data[COEFF_WIDTH-1:0];
                end
                REG_AWG_LEN: begin
                    ctrl_o.awg_len <= reg_wr_i.data[$bits(awg_addr_t)-1:0];
                end
                // Table window and unmapped addresses leave control alone
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/dac_interp.sv
`default_nettype none

module dac_interp
    import zest_dac_pkg::*;
(
    input  wire logic          dac_clk_out,
    input  wire logic          rst_n_i,
    // Input stream
    input  wire iq_sample_t    sample_i,
    input  wire logic          sample_valid_i,
    output logic               sample_ready_o,
    // Q1.14 gain
    input  wire interp_coeff_t coeff_i,
    // Two DAC-rate pairs per input pair
    output iq_sample_t         interp_o
);

    // ----------------------------------------------------------
    // Sequencing
    // ----------------------------------------------------------
    // Midpoint goes out in ST_MID, sample in ST_SMP
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MID,
        ST_SMP
    } interp_state_t;

    interp_state_t state_q;
    logic          accept;
    // Last accepted input, doubles as previous input for the midpoint
    iq_sample_t    cur_q;
    iq_sample_t    mid_q;

    // Busy only in the cycle after an accept
    assign sample_ready_o = (state_q != ST_MID);
    assign accept         = sample_valid_i && sample_ready_o;

    // Average of two samples, 15 bit sum then halve
    function automatic dac_word_t midpoint(input dac_word_t a, input dac_word_t b);
        logic signed [DAC_WIDTH:0] sum;
        sum = a + b;
        return sum[DAC_WIDTH:1];
    endfunction

    // Gain, drop fraction, clip to DAC range
    function automatic dac_word_t scale_sat(input dac_word_t v, input interp_coeff_t c);
        logic signed [PROD_WIDTH-1:0] prod;
        logic signed [PROD_WIDTH-1:0] shifted;
        dac_word_t                    res;
        prod    = v * $signed({1'b0, c});
        shifted = prod >>> INTERP_FRAC_BITS;
        if (shifted > DAC_MAX) begin
            res = DAC_MAX;
        end else if (shifted < DAC_MIN) begin
            res = DAC_MIN;
        end else begin
            res = shifted[DAC_WIDTH-1:0];
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Stage 1 input capture
    // ----------------------------------------------------------
    // Midpoint formed against the previous input before it is replaced
    always_ff @(posedge dac_clk_out) begin
        if (accept) begin
            mid_q.i <= midpoint(cur_q.i, sample_i.i);
            mid_q.q <= midpoint(cur_q.q, sample_i.q);
        end
    end

    // ----------------------------------------------------------
    // Stage 2 scale and saturate
    // ----------------------------------------------------------
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            cur_q    <= '0;
            interp_o <= '0;
        end else begin
            if (accept) begin
                cur_q <= sample_i;
            end
            case (state_q)
                ST_MID: begin
                    interp_o.i <= scale_sat(mid_q.i, coeff_i);
                    interp_o.q <= scale_sat(mid_q.q, coeff_i);
                    state_q    <= ST_SMP;
                end
                ST_SMP: begin
                    // cur_q still holds the old sample on this edge
                    interp_o.i <= scale_sat(cur_q.i, coeff_i);
                    interp_o.q <= scale_sat(cur_q.q, coeff_i);
                    state_q    <= accept ? ST_MID : ST_IDLE;
                end
                // Output holds the last scaled pair
                default: begin
                    state_q <= accept ? ST_MID : ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/dac_output_stage.sv
`default_nettype none

module dac_output_stage
    import zest_dac_pkg::*;
    import zest_reg_pkg::*;
(
    input  wire logic       dac_clk_out,
    input  wire logic       rst_n_i,
    // Enables and source selects
    input  wire dac_ctrl_t  ctrl_i,
    // Sample sources
    input  wire iq_sample_t interp_i,
    input  wire dac_word_t  awg_i,
    // Registered DDR frame
    output dac_ddr_t        dac_ddr_o
);

    dac_word_t lane_i;
    dac_word_t lane_q;

    // Zero when disabled, else AWG or interpolator
    function automatic dac_word_t lane_sel(input logic      enable,
                                           input logic      srcsel,
                                           input dac_word_t interp,
                                           input dac_word_t awg);
        dac_word_t res;
        if (!enable) begin
            res = '0;
        end else if (srcsel) begin
            res = awg;
        end else begin
            res = interp;
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Source mux
    // ----------------------------------------------------------
    always_comb begin
        lane_i = lane_sel(ctrl_i.dac0_enable, ctrl_i.dac0_srcsel, interp_i.i, awg_i);
        lane_q = lane_sel(ctrl_i.dac1_enable, ctrl_i.dac1_srcsel, interp_i.q, awg_i);
    end

    // I on the rising half with DCI high, Q on the falling half
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            dac_ddr_o <= '0;
        end else begin
            dac_ddr_o.rise <= {DCI_RISE, lane_i};
            dac_ddr_o.fall <= {DCI_FALL, lane_q};
        end
    end

endmodule

`default_nettype wire

// File: src/zest_dac_pkg.sv
`default_nettype none

// Sample, frame and interpolator definitions for the DAC datapath
package zest_dac_pkg;

    // ----------------------------------------------------------
    // Sample widths
    // ----------------------------------------------------------
    // Converter data width
    localparam int DAC_WIDTH = 14;

    // Signed two's complement DAC sample
    typedef logic signed [DAC_WIDTH-1:0] dac_word_t;

    // I and Q lanes, I in the upper half
    typedef struct packed {
        dac_word_t i;
        dac_word_t q;
    } iq_sample_t;

    // Saturation limits
    localparam dac_word_t DAC_MAX = {1'b0, {(DAC_WIDTH-1){1'b1}}};
    localparam dac_word_t DAC_MIN = {1'b1, {(DAC_WIDTH-1){1'b0}}};

    // ----------------------------------------------------------
    // DDR output frame
    // ----------------------------------------------------------
    // DCI marker on top of the data bits
    typedef logic [DAC_WIDTH:0] ddr_half_t;

    // Rising half first, falling half second
    typedef struct packed {
        ddr_half_t rise;
        ddr_half_t fall;
    } dac_ddr_t;

    // DCI levels per half
    localparam logic DCI_RISE = 1'b1;
    localparam logic DCI_FALL = 1'b0;

    // ----------------------------------------------------------
    // Interpolator
    // ----------------------------------------------------------
    localparam int INTERP_FRAC_BITS = 14;
    localparam int COEFF_WIDTH = INTERP_FRAC_BITS + 1;
    // Q1.14 gain, unsigned
    typedef logic [COEFF_WIDTH-1:0] interp_coeff_t;
    localparam interp_coeff_t COEFF_UNITY = interp_coeff_t'(1 << INTERP_FRAC_BITS);
    // Sample times coefficient with sign bit
    localparam int PROD_WIDTH = DAC_WIDTH + COEFF_WIDTH + 1;

endpackage

`default_nettype wire

// File: src/zest_dac_top.sv
`default_nettype none

module zest_dac_top
    import zest_dac_pkg::*;
    import zest_reg_pkg::*;
(
    input  wire logic       dac_clk_out,
    input  wire logic       rst_n_i,
    // Register write bus
    input  wire reg_wr_t    reg_wr_i,
    // Sample stream, valid/ready
    input  wire iq_sample_t sample_i,
    input  wire logic       sample_valid_i,
    output logic            sample_ready_o,
    // DDR frame to the DAC
    output dac_ddr_t        dac_ddr_o
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    dac_ctrl_t  ctrl;
    logic       awg_wr_en;
    awg_addr_t  awg_wr_addr;
    dac_word_t  awg_wr_data;
    iq_sample_t interp_sample;
    dac_word_t  awg_sample;

    // Control state and table load
    dac_ctrl_regs dac_ctrl_regs_i (
        .dac_clk_out   (dac_clk_out),
        .rst_n_i       (rst_n_i),
        .reg_wr_i      (reg_wr_i),
        .ctrl_o        (ctrl),
        .awg_wr_en_o   (awg_wr_en),
        .awg_wr_addr_o (awg_wr_addr),
        .awg_wr_data_o (awg_wr_data)
    );

    // Midpoint then sample, two cycles per input
    dac_interp dac_interp_i (
        .dac_clk_out    (dac_clk_out),
        .rst_n_i        (rst_n_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .coeff_i        (ctrl.coeff),
        .interp_o       (interp_sample)
    );

    // Self-test waveform source
    awg_player awg_player_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .run_i       (ctrl.awg_run),
        .last_idx_i  (ctrl.awg_len),
        .wr_en_i     (awg_wr_en),
        .wr_addr_i   (awg_wr_addr),
        .wr_data_i   (awg_wr_data),
        .awg_o       (awg_sample)
    );

    // Lane mux and DDR frame register
    dac_output_stage dac_output_stage_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .interp_i    (interp_sample),
        .awg_i       (awg_sample),
        .dac_ddr_o   (dac_ddr_o)
    );

endmodule

`default_nettype wire

// File: src/zest_reg_pkg.sv
`default_nettype none

// Register bus and control map of the DAC block
package zest_reg_pkg;

    // ----------------------------------------------------------
    // Write bus
    // ----------------------------------------------------------
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Write strobe with address and data
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    // AWG table size and index
    localparam int AWG_DEPTH = 64;
    typedef logic [$clog2(AWG_DEPTH)-1:0] awg_addr_t;

    // ----------------------------------------------------------
    // Register map
    // ----------------------------------------------------------
    localparam reg_addr_t REG_DAC_CTRL     = 8'h00;
    localparam reg_addr_t REG_INTERP_COEFF = 8'h01;
    // Last table index played
    localparam reg_addr_t REG_AWG_LEN      = 8'h02;
    // Table window
    localparam reg_addr_t REG_AWG_BASE     = 8'h40;
    localparam reg_addr_t REG_AWG_LAST     = 8'h7F;

    // REG_DAC_CTRL bits
    localparam int BIT_DAC0_SRCSEL = 0;
    localparam int BIT_DAC0_ENABLE = 1;
    localparam int BIT_DAC1_SRCSEL = 2;
    localparam int BIT_DAC1_ENABLE = 3;
    localparam int BIT_AWG_RUN     = 4;

    // Decoded control state
    typedef struct packed {
        logic                        awg_run;
        logic                        dac1_enable;
        logic                        dac1_srcsel;
        logic                        dac0_enable;
        logic                        dac0_srcsel;
        zest_dac_pkg::interp_coeff_t coeff;
        awg_addr_t                   awg_len;
    } dac_ctrl_t;

endpackage

`default_nettype wire

// File: test/zest_dac_checker.sv
`default_nettype none

module zest_dac_checker
    import zest_dac_pkg::*;
(
    input wire logic     dac_clk_out,
    input wire logic     rst_n_i,
    input wire logic     sample_valid_i,
    input wire logic     sample_ready_i,
    input wire dac_ddr_t dac_ddr_i
);

    // Failed assertion count, read by the testbench
    int assert_errors = 0;

    // Frame register cleared by every reset edge
    reset_clears_frame: assert property (
        @(posedge dac_clk_out) !rst_n_i |=> (dac_ddr_i == '0)
    ) else begin
        $error("dac_ddr_o not zero after a reset edge");
        assert_errors++;
    end

    // First registered frame carries the DCI markers
    dci_after_reset: assert property (
        @(posedge dac_clk_out) $rose(rst_n_i) |=>
            (dac_ddr_i.rise[DAC_WIDTH] == DCI_RISE) && (dac_ddr_i.fall[DAC_WIDTH] == DCI_FALL)
    ) else begin
        $error("DCI bits wrong in the first frame after reset");
        assert_errors++;
    end

    // Interpolator busy for one cycle per accept
    ready_low_after_accept: assert property (
        @(posedge dac_clk_out) disable iff (!rst_n_i)
            (sample_valid_i && sample_ready_i) |=> !sample_ready_i
    ) else begin
        $error("sample_ready_o high in the cycle after an accept");
        assert_errors++;
    end

endmodule

bind zest_dac_top zest_dac_checker zest_dac_checker_i (
    .dac_clk_out    (dac_clk_out),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_ready_i (sample_ready_o),
    .dac_ddr_i      (dac_ddr_o)
);

`default_nettype wire

// File: test/zest_dac_tb.sv
`default_nettype none

module zest_dac_tb
    import zest_dac_pkg::*;
    import zest_reg_pkg::*;
();

    // ----------------------------------------------------------
    // Run lengths
    // ----------------------------------------------------------
    localparam int CLK_PERIOD    = 8;
    localparam int RST_CYCLES    = 4;
    localparam int N_BASIC       = 8;
    localparam int N_INTERP      = 48;
    localparam int N_SCALE       = 24;
    localparam int N_AWG         = 40;
    localparam int N_GATE        = 32;
    localparam int DRAIN_CYCLES  = 8;
    localparam int HS_TIMEOUT    = 10;
    // Drive, ready wait and up to 3 gap cycles
    localparam int SAMPLE_CYCLES = 6;
    localparam int WRITE_CYCLES  = 2;
    localparam int TEST_CYCLES   = RST_CYCLES + 2
        + 3 * WRITE_CYCLES + N_BASIC * SAMPLE_CYCLES + DRAIN_CYCLES + 1
        + WRITE_CYCLES + N_INTERP * SAMPLE_CYCLES + DRAIN_CYCLES
        + 2 * (WRITE_CYCLES + (N_SCALE + 2) * SAMPLE_CYCLES + DRAIN_CYCLES) + WRITE_CYCLES
        + (AWG_DEPTH + 2) * WRITE_CYCLES + N_AWG * SAMPLE_CYCLES + DRAIN_CYCLES
        + WRITE_CYCLES + N_GATE * (WRITE_CYCLES + SAMPLE_CYCLES) + DRAIN_CYCLES;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + 100) * CLK_PERIOD;
    localparam logic [15:0] LFSR_SEED = 16'd50500;

    logic       dac_clk_out;
    logic       rst_n_i;
    reg_wr_t    reg_wr_i;
    iq_sample_t sample_i;
    logic       sample_valid_i;
    logic       sample_ready_o;
    dac_ddr_t   dac_ddr_o;

    logic [15:0] lfsr_q;
    int          errors = 0;
    int          checks_run = 0;

    // Reference model state, one value per clock cycle
    dac_ctrl_t   m_ctrl;
    iq_sample_t  m_interp;
    iq_sample_t  m_prev;
    iq_sample_t  pend_a_val;
    iq_sample_t  pend_b_val;
    logic        pend_a;
    logic        pend_b;
    dac_word_t   m_awg;
    awg_addr_t   m_idx;
    logic        m_ready;
    dac_word_t   m_table [AWG_DEPTH];
    dac_ddr_t    exp_q [$];

    zest_dac_top zest_dac_top_i (
        .dac_clk_out    (dac_clk_out),
        .rst_n_i        (rst_n_i),
        .reg_wr_i       (reg_wr_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .dac_ddr_o      (dac_ddr_o)
    );

    always #(CLK_PERIOD / 2) dac_clk_out = ~dac_clk_out;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          b;
        r = '0;
        for (b = 0; b < n; b++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // Halved sum of two samples
    function automatic dac_word_t expect_midpoint(input dac_word_t a, input dac_word_t b);
        int s;
        s = int'(a) + int'(b);
        return dac_word_t'(s >>> 1);
    endfunction

    // Q1.14 gain then clip to the DAC range
    function automatic dac_word_t expect_scaled(input dac_word_t v, input interp_coeff_t c);
        int p;
        p = (int'(v) * int'(c)) >>> INTERP_FRAC_BITS;
        if (p > int'(DAC_MAX)) begin
            p = int'(DAC_MAX);
        end else if (p < int'(DAC_MIN)) begin
            p = int'(DAC_MIN);
        end
        return dac_word_t'(p);
    endfunction

    // Disabled lane reads zero, srcsel picks the AWG
    function automatic dac_word_t pick_lane(input logic en, input logic src,
                                            input dac_word_t interp, input dac_word_t awg);
        dac_word_t r;
        r = !en ? '0 : (src ? awg : interp);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_run++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    // Single write strobe, two cycles
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge dac_clk_out);
        reg_wr_i.valid <= 1'b1;
        reg_wr_i.addr  <= addr;
        reg_wr_i.data  <= data;
        @(posedge dac_clk_out);
        reg_wr_i.valid <= 1'b0;
    endtask

    // Called on a rising edge; holds the sample until accepted
    task automatic send_sample(input iq_sample_t smp, input int gap);
        int   waited;
        logic ready_seen;
        sample_i       <= smp;
        sample_valid_i <= 1'b1;
        waited     = 0;
        ready_seen = 1'b0;
        while (!ready_seen && waited < HS_TIMEOUT) begin
            @(negedge dac_clk_out);
            ready_seen = sample_ready_o;
            @(posedge dac_clk_out);
            waited++;
        end
        if (!ready_seen) begin
            errors++;
            $display("Sample was not accepted: ready stayed low for %0d cycles", HS_TIMEOUT);
        end
        sample_valid_i <= 1'b0;
        repeat (gap) @(posedge dac_clk_out);
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    // Pre-edge values give the frame registered at this edge
    always @(posedge dac_clk_out) begin : model
        dac_ddr_t frame;
        logic     acc;
        if (!rst_n_i) begin
            m_ctrl     = '0;
            m_ctrl.coeff   = COEFF_UNITY;
            m_ctrl.awg_len = awg_addr_t'(AWG_DEPTH - 1);
            m_interp   = '0;
            m_prev     = '0;
            pend_a     = 1'b0;
            pend_b     = 1'b0;
            m_awg      = '0;
            m_idx      = '0;
            m_ready    = 1'b1;
            frame      = '0;
        end else begin
            frame.rise = {DCI_RISE, pick_lane(m_ctrl.dac0_enable, m_ctrl.dac0_srcsel,
                                              m_interp.i, m_awg)};
            frame.fall = {DCI_FALL, pick_lane(m_ctrl.dac1_enable, m_ctrl.dac1_srcsel,
                                              m_interp.q, m_awg)};
            // Table entry registered, index wraps after the last one
            m_awg = m_ctrl.awg_run ? m_table[m_idx] : '0;
            if (!m_ctrl.awg_run || m_idx >= m_ctrl.awg_len) begin
                m_idx = '0;
            end else begin
                m_idx = m_idx + 1'b1;
            end
            // Midpoint two cycles after accept, sample one cycle later
            acc = sample_valid_i && m_ready;
            if (pend_a) begin
                m_interp = pend_a_val;
            end
            pend_a     = pend_b;
            pend_a_val = pend_b_val;
            pend_b     = 1'b0;
            if (acc) begin
                pend_a       = 1'b1;
                pend_a_val.i = expect_scaled(expect_midpoint(m_prev.i, sample_i.i), m_ctrl.coeff);
                pend_a_val.q = expect_scaled(expect_midpoint(m_prev.q, sample_i.q), m_ctrl.coeff);
                pend_b       = 1'b1;
                pend_b_val.i = expect_scaled(sample_i.i, m_ctrl.coeff);
                pend_b_val.q = expect_scaled(sample_i.q, m_ctrl.coeff);
                m_prev       = sample_i;
            end
            m_ready = !acc;
            // Register map, other addresses dropped
            if (reg_wr_i.valid) begin
                case (reg_wr_i.addr)
                    REG_DAC_CTRL: begin
                        m_ctrl.dac0_srcsel = reg_wr_i.data[BIT_DAC0_SRCSEL];
                        m_ctrl.dac0_enable = reg_wr_i.data[BIT_DAC0_ENABLE];
                        m_ctrl.dac1_srcsel = reg_wr_i.data[BIT_DAC1_SRCSEL];
                        m_ctrl.dac1_enable = reg_wr_i.data[BIT_DAC1_ENABLE];
                        m_ctrl.awg_run     = reg_wr_i.data[BIT_AWG_RUN];
                    end
                    REG_INTERP_COEFF: m_ctrl.coeff = interp_coeff_t'(reg_wr_i.data);
                    REG_AWG_LEN: m_ctrl.awg_len = awg_addr_t'(reg_wr_i.data);
                    default: begin
                        if (reg_wr_i.addr >= REG_AWG_BASE && reg_wr_i.addr <= REG_AWG_LAST) begin
                            m_table[reg_wr_i.addr - REG_AWG_BASE] = dac_word_t'(reg_wr_i.data);
                        end
                    end
                endcase
            end
        end
        exp_q.push_back(frame);
    end

    // Outputs compared mid-cycle
    always @(negedge dac_clk_out) begin : compare
        dac_ddr_t exp_frame;
        if (exp_q.size() > 0) begin
            exp_frame = exp_q.pop_front();
            check_value("dac_ddr_o", dac_ddr_o, exp_frame);
            check_value("sample_ready_o", sample_ready_o, m_ready);
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin : main
        reg_data_t     both_interp;
        interp_coeff_t coeff;
        int            n;
        int            pass;
        int            total;
        dac_clk_out    = 1'b0;
        rst_n_i        = 1'b0;
        reg_wr_i       = '0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        lfsr_q         = LFSR_SEED;
        both_interp    = (1 << BIT_DAC0_ENABLE) | (1 << BIT_DAC1_ENABLE);
        repeat (RST_CYCLES) @(posedge dac_clk_out);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge dac_clk_out);

        // Lanes off, unmapped writes ignored
        bus_write(REG_DAC_CTRL, '0);
        bus_write(8'h03, rand_bits(32));
        bus_write(8'h80, rand_bits(32));
        for (n = 0; n < N_BASIC; n++) begin
            send_sample(iq_sample_t'(rand_bits(28)), int'(rand_bits(2)));
        end
        repeat (DRAIN_CYCLES) @(posedge dac_clk_out);
        @(negedge dac_clk_out);
        check_value("dac_ddr_o", dac_ddr_o, 32'h2000_0000);

        // Unity gain from the reset default, random valid gaps
        bus_write(REG_DAC_CTRL, both_interp);
        for (n = 0; n < N_INTERP; n++) begin
            send_sample(iq_sample_t'(rand_bits(28)), int'(rand_bits(2)));
        end
        repeat (DRAIN_CYCLES) @(posedge dac_clk_out);

        // Random gain, then gain of one or more to force clipping
        for (pass = 0; pass < 2; pass++) begin
            coeff = interp_coeff_t'(rand_bits(15));
            if (pass == 1) begin
                coeff[COEFF_WIDTH-1] = 1'b1;
            end
            bus_write(REG_INTERP_COEFF, reg_data_t'(coeff));
            send_sample({DAC_MAX, DAC_MIN}, 0);
            send_sample({DAC_MIN, DAC_MAX}, 0);
            for (n = 0; n < N_SCALE; n++) begin
                send_sample(iq_sample_t'(rand_bits(28)), int'(rand_bits(2)));
            end
            repeat (DRAIN_CYCLES) @(posedge dac_clk_out);
        end
        bus_write(REG_INTERP_COEFF, reg_data_t'(COEFF_UNITY));

        // AWG on lane I, Q stays on the interpolator
        for (n = 0; n < AWG_DEPTH; n++) begin
            bus_write(REG_AWG_BASE + reg_addr_t'(n), rand_bits(DAC_WIDTH));
        end
        bus_write(REG_AWG_LEN, rand_bits(6));
        bus_write(REG_DAC_CTRL, both_interp | (1 << BIT_DAC0_SRCSEL) | (1 << BIT_AWG_RUN));
        for (n = 0; n < N_AWG; n++) begin
            send_sample(iq_sample_t'(rand_bits(28)), int'(rand_bits(2)));
        end
        repeat (DRAIN_CYCLES) @(posedge dac_clk_out);
        bus_write(REG_DAC_CTRL, both_interp);

        // Random enables, selects and run
        for (n = 0; n < N_GATE; n++) begin
            bus_write(REG_DAC_CTRL, rand_bits(5));
            send_sample(iq_sample_t'(rand_bits(28)), int'(rand_bits(2)));
        end
        repeat (DRAIN_CYCLES) @(posedge dac_clk_out);

        total = errors + zest_dac_top_i.zest_dac_checker_i.assert_errors;
        $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
                 checks_run, errors, zest_dac_top_i.zest_dac_checker_i.assert_errors);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/zest_dac_pkg.sv
src/zest_reg_pkg.sv
src/dac_ctrl_regs.sv
src/dac_interp.sv
src/awg_player.sv
src/dac_output_stage.sv
src/zest_dac_top.sv
test/zest_dac_checker.sv
test/zest_dac_tb.sv
